// ==== source/hdc_cfg_pkg.sv ====
`default_nettype none

package hdc_cfg_pkg;

    // hypervector geometry
    localparam int HV_BITS = 128;
    localparam int RAND_BITS = 32;
    localparam int HV_WORDS = HV_BITS / RAND_BITS;

    // item memory addressing, 512 entries at most
    localparam int ITEM_ADDR_BITS = 9;

    // one full hypervector
    typedef logic [HV_BITS-1:0] hv_t;

    // item memory address
    typedef logic [ITEM_ADDR_BITS-1:0] item_addr_t;

    // index of a 32-bit word inside a hypervector
    typedef logic [$clog2(HV_WORDS)-1:0] word_idx_t;

    // xorshift32 start value, loaded on reset and on re-seed
    localparam logic [RAND_BITS-1:0] XORSHIFT_SEED = 32'h92D68CA2;

    // xorshift32 shift amounts
    localparam int XS_SHIFT_A = 13;
    localparam int XS_SHIFT_B = 17;
    localparam int XS_SHIFT_C = 5;

endpackage

`default_nettype wire

// ==== source/hdc_isa_pkg.sv ====
`default_nettype none

package hdc_isa_pkg;

    import hdc_cfg_pkg::*;

    // instruction opcodes, top 4 bits of the instruction word
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_LOAD  = 4'd1,
        OP_BIND  = 4'd2,
        OP_PERM  = 4'd3,
        OP_MOVE  = 4'd4,
        OP_STORE = 4'd5,
        OP_WB    = 4'd6,
        OP_LAST  = 4'd7
    } hdc_op_e;

    // 16-bit instruction word
    typedef struct packed {
        hdc_op_e    opcode;
        logic [2:0] spare;
        // item address, or rotate amount for OP_PERM
        item_addr_t arg;
    } instr_t;

    // item memory write request
    typedef struct packed {
        logic       en;
        item_addr_t addr;
        hv_t        data;
    } item_wr_t;

    // item memory read request
    typedef struct packed {
        item_addr_t addr;
    } item_rd_t;

endpackage

`default_nettype wire

// ==== source/hv_generator.sv ====
`default_nettype none
`timescale 1ns/1ps

module hv_generator
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int ITEM_DEPTH = 64
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             gen,
    input  wire             reset_item,
    input  wire item_addr_t item_count,
    output item_wr_t        gen_wr,
    output logic            gen_done
);

    localparam word_idx_t LAST_WORD = word_idx_t'(HV_WORDS - 1);

    logic [RAND_BITS-1:0] rng_state;
    logic [RAND_BITS-1:0] rng_next;
    word_idx_t            word_idx;
    hv_t                  asm_hv;
    item_addr_t           item_addr;
    item_addr_t           last_addr;
    logic                 wr_pend;
    logic                 gen_finished;

    // one xorshift32 step
    function automatic logic [RAND_BITS-1:0] xorshift32(input logic [RAND_BITS-1:0] x);
        logic [RAND_BITS-1:0] y;
        y = x ^ (x << XS_SHIFT_A);
        y = y ^ (y >> XS_SHIFT_B);
        y = y ^ (y << XS_SHIFT_C);
        return y;
    endfunction

    assign rng_next = xorshift32(rng_state);

    // final item address, clipped to what the memory holds
    always_comb begin
        if (int'(item_count) > ITEM_DEPTH) begin
            last_addr = item_addr_t'(ITEM_DEPTH - 1);
        end else begin
            last_addr = item_count - item_addr_t'(1);
        end
    end

    // seed state survives gen going low
    always_ff @(posedge clk) begin
        if (!rst_n || reset_item) begin
            rng_state <= XORSHIFT_SEED;
        end else if (gen) begin
            rng_state <= rng_next;
        end
    end

    // word assembly, word 0 lands in bits 31:0
    always_ff @(posedge clk) begin
        if (gen) begin
            asm_hv[word_idx*RAND_BITS +: RAND_BITS] <= rng_next;
        end
    end

    // word and item sequencing
    always_ff @(posedge clk) begin
        if (!rst_n || !gen) begin
            word_idx     <= '0;
            item_addr    <= '0;
            wr_pend      <= 1'b0;
            gen_finished <= 1'b0;
        end else begin
            if (word_idx == LAST_WORD) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + word_idx_t'(1);
            end
            // vector complete after the last word, write it next cycle
            wr_pend <= (word_idx == LAST_WORD) && !gen_finished;
            if (gen_wr.en) begin
                item_addr <= item_addr + item_addr_t'(1);
            end
            if (gen_done) begin
                gen_finished <= 1'b1;
            end
        end
    end

    assign gen_wr.en   = wr_pend && gen && !gen_finished;
    assign gen_wr.addr = item_addr;
    assign gen_wr.data = asm_hv;

    // high only while the final item is written
    assign gen_done = gen_wr.en && (item_addr == last_addr);

endmodule

`default_nettype wire

// ==== source/item_memory.sv ====
`default_nettype none
`timescale 1ns/1ps

module item_memory
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int ITEM_DEPTH = 64
) (
    input  wire           clk,
    input  wire item_wr_t gen_wr,
    input  wire item_wr_t wb_wr,
    input  wire item_rd_t rd_req,
    output hv_t           rd_data
);

    localparam int IDX_BITS = (ITEM_DEPTH > 1) ? $clog2(ITEM_DEPTH) : 1;

    hv_t                 mem [ITEM_DEPTH];
    logic [IDX_BITS-1:0] wr_idx;
    logic [IDX_BITS-1:0] rd_idx;
    hv_t                 wr_data;
    logic                wr_en;

    // single write port, write-back wins over the generator
    always_comb begin
        if (wb_wr.en) begin
            wr_idx  = wb_wr.addr[IDX_BITS-1:0];
            wr_data = wb_wr.data;
        end else begin
            wr_idx  = gen_wr.addr[IDX_BITS-1:0];
            wr_data = gen_wr.data;
        end
    end

    assign wr_en  = wb_wr.en || gen_wr.en;
    assign rd_idx = rd_req.addr[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        // read sees the old contents on a same-address write
        rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

// ==== source/hv_datapath.sv ====
`default_nettype none
`timescale 1ns/1ps

module hv_datapath
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         instr_valid,
    input  wire instr_t instr,
    input  wire hv_t    rd_data,
    output item_rd_t    rd_req,
    output item_wr_t    wb_wr,
    output logic        store,
    output hv_t         result,
    output logic        last
);

    localparam int ROT_BITS = $clog2(HV_BITS);

    localparam instr_t NOP_INSTR = '{
        opcode: OP_NOP,
        spare:  3'b000,
        arg:    '0
    };

    instr_t              ir;
    hv_t                 reg1;
    hv_t                 reg2;
    logic [ROT_BITS-1:0] rot_amt;

    // rotate left, amount already reduced modulo HV_BITS
    function automatic hv_t rotl(input hv_t v, input logic [ROT_BITS-1:0] n);
        return (v << n) | (v >> (HV_BITS - int'(n)));
    endfunction

    // item read starts as soon as the instruction arrives
    assign rd_req.addr = instr.arg;

    // stage 1, instruction register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= NOP_INSTR;
        end else if (instr_valid) begin
            ir <= instr;
        end else begin
            ir <= NOP_INSTR;
        end
    end

    assign rot_amt = ir.arg[ROT_BITS-1:0];

    // stage 2, execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg1  <= '0;
            reg2  <= '0;
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= (ir.opcode == OP_STORE);
            last  <= (ir.opcode == OP_LAST);
            case (ir.opcode)
                OP_LOAD: begin
                    reg2 <= rd_data;
                end
                OP_BIND: begin
                    reg2 <= reg1 ^ reg2;
                end
                OP_PERM: begin
                    reg2 <= rotl(reg2, rot_amt);
                end
                OP_MOVE: begin
                    reg1 <= reg2;
                end
                // store, wb, last and nop leave the registers alone
                default: begin
                end
            endcase
        end
    end

    // write-back lands on the execute edge
    assign wb_wr.en   = (ir.opcode == OP_WB);
    assign wb_wr.addr = ir.arg;
    assign wb_wr.data = reg2;

    // reg2 is unchanged by STORE, so it still holds the stored value
    assign result = store ? reg2 : '0;

endmodule

`default_nettype wire

// ==== source/hdc_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module hdc_core
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int ITEM_DEPTH = 64
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             gen,
    input  wire             reset_item,
    input  wire item_addr_t item_count,
    input  wire             instr_valid,
    input  wire instr_t     instr,
    output logic            gen_done,
    output logic            store,
    output hv_t             result,
    output logic            last
);

    item_wr_t gen_wr;
    item_wr_t wb_wr;
    item_rd_t rd_req;
    hv_t      rd_data;

    // fills the item memory while gen is high
    hv_generator #(
        .ITEM_DEPTH(ITEM_DEPTH)
    ) u_hv_generator (
        .clk        (clk),
        .rst_n      (rst_n),
        .gen        (gen),
        .reset_item (reset_item),
        .item_count (item_count),
        .gen_wr     (gen_wr),
        .gen_done   (gen_done)
    );

    item_memory #(
        .ITEM_DEPTH(ITEM_DEPTH)
    ) u_item_memory (
        .clk     (clk),
        .gen_wr  (gen_wr),
        .wb_wr   (wb_wr),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

    hv_datapath u_hv_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data     (rd_data),
        .rd_req      (rd_req),
        .wb_wr       (wb_wr),
        .store       (store),
        .result      (result),
        .last        (last)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // reset held through the first two rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/hdc_core_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module hdc_core_props
    import hdc_cfg_pkg::*;
(
    input wire      clk,
    input wire      rst_n,
    input wire      gen,
    input wire      gen_done,
    input wire      store,
    input wire      last,
    input wire hv_t result
);

    // store and last come from different opcodes
    a_store_last: assert property (@(posedge clk) disable iff (!rst_n) !(store && last))
        else $error("store and last high in the same cycle");

    a_result_idle: assert property (@(posedge clk) disable iff (!rst_n) !store |-> result == '0)
        else $error("result not zero while store is low");

    a_done_in_gen: assert property (@(posedge clk) disable iff (!rst_n) gen_done |-> gen)
        else $error("gen_done high while gen is low");

    // pulses start out low once reset has been seen
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !store && !last && !gen_done)
        else $error("output pulse in the cycle after reset");

endmodule

bind hdc_core hdc_core_props u_hdc_core_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .gen      (gen),
    .gen_done (gen_done),
    .store    (store),
    .last     (last),
    .result   (result)
);

`default_nettype wire

// ==== bench/tb_hdc_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_hdc_core
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
();

    localparam int STEP_TIMEOUT = 64;

    logic       clk;
    logic       rst_n;
    logic       gen;
    logic       reset_item;
    item_addr_t item_count;
    logic       instr_valid;
    instr_t     instr;
    logic       gen_done;
    logic       store;
    hv_t        result;
    logic       last;

    // reference items and pending output checks
    hv_t        item_ref [8];
    int         due_q [$];
    string      name_q [$];
    string      kind_q [$];
    hv_t        hv_q [$];
    int         slot = 0;
    logic [7:0] lfsr;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hdc_core u_hdc_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .gen         (gen),
        .reset_item  (reset_item),
        .item_count  (item_count),
        .instr_valid (instr_valid),
        .instr       (instr),
        .gen_done    (gen_done),
        .store       (store),
        .result      (result),
        .last        (last)
    );

    task automatic stop_failed();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_hv(input string test_name, input hv_t expected, input hv_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string test_name, input bit expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", test_name, expected, actual);
            stop_failed();
        end
    endtask

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // item n holds steps 4n+1 to 4n+4, the first of them in bits 31:0
    task automatic build_item_refs();
        logic [31:0] s;
        s = XORSHIFT_SEED;
        for (int n = 0; n < 8; n++) begin
            for (int w = 0; w < HV_WORDS; w++) begin
                s = xorshift_step(s);
                item_ref[n][w*RAND_BITS +: RAND_BITS] = s;
            end
        end
    endtask

    function automatic hv_t rotate_left(input hv_t v, input int n);
        hv_t r;
        for (int i = 0; i < HV_BITS; i++) begin
            r[(i + n) % HV_BITS] = v[i];
        end
        return r;
    endfunction

    // b below zero means item a alone
    function automatic hv_t expected_vector(input int a, input int b, input int rot);
        hv_t v;
        v = item_ref[a];
        if (b >= 0) begin
            v = v ^ item_ref[b];
        end
        return rotate_left(v, rot);
    endfunction

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
    endtask

    task automatic insert_idle_gap();
        int n;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | int'(lfsr[0]);
        end
        repeat (n) drive_idle();
    endtask

    // outputs show in the slot after the second edge that follows the drive edge
    task automatic issue_instr(input string test_name, input instr_t word, input string kind,
                               input int a, input int b, input int rot);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        due_q.push_back(slot + 3);
        name_q.push_back(test_name);
        kind_q.push_back(kind);
        hv_q.push_back((kind == "hv") ? expected_vector(a, b, rot) : '0);
    endtask

    task automatic wait_drained(input string test_name);
        int waited;
        waited = 0;
        drive_idle();
        while (due_q.size() > 0) begin
            drive_idle();
            waited++;
            if (waited > STEP_TIMEOUT) begin
                $display("%s: expected outputs never appeared", test_name);
                stop_failed();
            end
        end
    endtask

    task automatic run_generation(input string test_name, input item_addr_t count);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        wait_drained(test_name);
        @(posedge clk);
        item_count <= count;
        gen        <= 1'b1;
        while (!seen) begin
            @(negedge clk);
            seen = (gen_done === 1'b1);
            waited++;
            if (!seen && waited > 4 * int'(count) + 16) begin
                $display("%s: gen_done did not arrive in time", test_name);
                stop_failed();
            end
        end
        @(posedge clk);
        gen <= 1'b0;
    endtask

    task automatic pulse_reseed(input string test_name);
        wait_drained(test_name);
        @(posedge clk);
        reset_item <= 1'b1;
        @(posedge clk);
        reset_item <= 1'b0;
    endtask

    // one slot per clock period, outputs checked mid-period
    always @(negedge clk) begin
        string test_name;
        string kind;
        hv_t   expected;
        slot      = slot + 1;
        test_name = "idle";
        kind      = "none";
        expected  = '0;
        if (due_q.size() > 0 && due_q[0] == slot) begin
            void'(due_q.pop_front());
            test_name = name_q.pop_front();
            kind      = kind_q.pop_front();
            expected  = hv_q.pop_front();
        end
        if (rst_n) begin
            check_flag({test_name, " store"}, kind == "hv", store);
            check_flag({test_name, " last"}, kind == "last", last);
            check_hv({test_name, " result"}, expected, result);
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          waited;
        string       line;
        string       cmd;
        string       test_name;
        string       kind;
        logic [31:0] arg;
        int          a;
        int          b;
        int          rot;
        gen         <= 1'b0;
        reset_item  <= 1'b0;
        item_count  <= '0;
        instr_valid <= 1'b0;
        instr       <= '0;
        lfsr        = 8'd76;
        waited      = 0;
        build_item_refs();
        fd = $fopen("bench/hdc_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/hdc_patterns.txt");
            stop_failed();
        end
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > 8) begin
                $display("reset was never released");
                stop_failed();
            end
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %s %h %s %d %d %d", cmd, test_name, arg, kind, a, b, rot);
            if (line.len() > 0 && line.substr(0, 0) != "#" && fields > 0) begin
                if (fields != 7) begin
                    $display("malformed pattern line: %s", line);
                    stop_failed();
                end else if (cmd == "gen") begin
                    run_generation(test_name, item_addr_t'(arg));
                end else if (cmd == "reseed") begin
                    pulse_reseed(test_name);
                end else if (cmd == "ins") begin
                    insert_idle_gap();
                    issue_instr(test_name, instr_t'(arg[15:0]), kind, a, b, rot);
                end else if (cmd == "seq") begin
                    issue_instr(test_name, instr_t'(arg[15:0]), kind, a, b, rot);
                end else begin
                    $display("unknown pattern command: %s", cmd);
                    stop_failed();
                end
            end
        end
        $fclose(fd);
        wait_drained("end_of_run");
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/hdc_patterns.txt ====
# columns: cmd test arg(hex) check a b rot
# gen: arg is item_count; ins: idle gap first; seq: issued back to back; hv: rotl(item a ^ item b, rot)
gen     gen_items   0008  none  -1  -1  0
ins     gen_items   1000  none  -1  -1  0
ins     gen_items   5000  hv     0  -1  0
ins     gen_items   1001  none  -1  -1  0
ins     gen_items   5000  hv     1  -1  0
ins     gen_items   1007  none  -1  -1  0
ins     gen_items   5000  hv     7  -1  0
ins     bind_perm   1002  none  -1  -1  0
ins     bind_perm   4000  none  -1  -1  0
ins     bind_perm   1005  none  -1  -1  0
ins     bind_perm   2000  none  -1  -1  0
ins     bind_perm   5000  hv     2   5  0
ins     bind_perm   3005  none  -1  -1  0
ins     bind_perm   5000  hv     2   5  5
ins     write_back  1003  none  -1  -1  0
ins     write_back  6014  none  -1  -1  0
ins     write_back  0000  none  -1  -1  0
ins     write_back  1014  none  -1  -1  0
ins     write_back  5000  hv     3  -1  0
seq     back2back   1004  none  -1  -1  0
seq     back2back   5000  hv     4  -1  0
seq     back2back   1006  none  -1  -1  0
seq     back2back   5000  hv     6  -1  0
seq     back2back   2000  none  -1  -1  0
seq     back2back   5000  hv     2   6  0
seq     back2back   3001  none  -1  -1  0
seq     back2back   5000  hv     2   6  1
ins     last_flag   7000  last  -1  -1  0
ins     last_flag   0000  none  -1  -1  0
ins     reseed      6000  none  -1  -1  0
ins     reseed      0000  none  -1  -1  0
ins     reseed      1000  none  -1  -1  0
ins     reseed      5000  hv     2   6  1
reseed  reseed      0000  none  -1  -1  0
gen     reseed      0001  none  -1  -1  0
ins     reseed      1000  none  -1  -1  0
ins     reseed      5000  hv     0  -1  0

// ==== list.f ====
source/hdc_cfg_pkg.sv
source/hdc_isa_pkg.sv
source/hv_generator.sv
source/item_memory.sv
source/hv_datapath.sv
source/hdc_core.sv
bench/tb_clock.sv
bench/hdc_core_props.sv
bench/tb_hdc_core.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_hdc_core

.PHONY: all run clean

all: run

$(BIN): list.f $(wildcard source/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --top-module tb_hdc_core -f list.f

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@grep -qx 'Test completed successfully' sim.log

clean:
	rm -rf obj_dir sim.log
